// ==== compile.f ====
src/conv_pkg.sv
src/sample_ram.sv
src/load_ctrl.sv
src/window_counter.sv
src/conv_ctrl.sv
src/mac_acc.sv
src/out_fifo.sv
src/conv_top.sv
verification/conv_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the conv_top testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module conv_tb -f compile.f -o conv_sim

status=0
./obj_dir/conv_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Test failed" sim.log; then
    exit 1
fi
exit 0

// ==== verification/conv_tb.sv ====
//----------------------------------------
// conv_top testbench: directed frames checked
// against a software convolution model
//----------------------------------------
module conv_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import conv_pkg::*;

    localparam int    WAIT_LIMIT = 1000;          // cycles per wait before giving up
    localparam data_t D_MAX      = data_t'(18'h1FFFF);
    localparam data_t D_MIN      = data_t'(18'h20000);

    logic  clk;
    logic  reset;
    data_t i_in_data;
    logic  i_in_valid;
    user_t i_in_user;
    logic  o_in_ready;
    acc_t  o_out_data;
    logic  o_out_valid;
    logic  i_out_ready;

    data_t w_mem [MAX_K*MAX_K];                   // software copy of the weights
    data_t x_mem [IMG_R*IMG_C];
    data_t bias_v;
    int    k_v;
    acc_t  exp_q [$];                             // expected results, row-major
    int    checks;
    int    errors;
    int    timeouts;
    int unsigned seed_val;

    conv_top dut0 (
        .clk         (clk),
        .reset       (reset),
        .i_in_data   (i_in_data),
        .i_in_valid  (i_in_valid),
        .i_in_user   (i_in_user),
        .o_in_ready  (o_in_ready),
        .o_out_data  (o_out_data),
        .o_out_valid (o_out_valid),
        .i_out_ready (i_out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //----------------------------------------
    // compare tasks
    //----------------------------------------
    task automatic check_acc(input acc_t got, input acc_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s, got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s, got %b expected %b", $time, what, got, exp);
        end
    endtask

    //----------------------------------------
    // stimulus and model
    //----------------------------------------
    function automatic data_t pick_extreme();
        return (($urandom & 32'd1) != 32'd0) ? D_MAX : D_MIN;
    endfunction

    function automatic void fill_image_random();
        for (int n = 0; n < IMG_R*IMG_C; n++) x_mem[n] = data_t'($urandom);
    endfunction

    function automatic void fill_weights_random(input int k);
        k_v = k;
        for (int n = 0; n < k*k; n++) w_mem[n] = data_t'($urandom);
        bias_v = data_t'($urandom);
    endfunction

    // bias plus window sum for every valid output position
    function automatic void model_conv();
        acc_t sum;
        exp_q.delete();
        for (int r = 0; r <= IMG_R - k_v; r++) begin
            for (int c = 0; c <= IMG_C - k_v; c++) begin
                sum = acc_t'(bias_v);
                for (int i = 0; i < k_v; i++) begin
                    for (int j = 0; j < k_v; j++) begin
                        sum = sum + acc_t'(x_mem[(r+i)*IMG_C + c + j]) * acc_t'(w_mem[i*k_v + j]);
                    end
                end
                exp_q.push_back(sum);
            end
        end
    endfunction

    task automatic send_word(input data_t d, input user_t u);
        int cycles;
        if (timeouts != 0) return;
        i_in_data  <= d;
        i_in_user  <= u;
        i_in_valid <= 1'b1;
        cycles = 0;
        @(negedge clk);
        while (!o_in_ready) begin
            if (cycles == WAIT_LIMIT) begin
                $display("timeout at %0t: input side never became ready", $time);
                timeouts++;
                return;
            end
            cycles++;
            @(negedge clk);
        end
        @(posedge clk);                               // word accepted here
    endtask

    task automatic send_frame(input logic new_w);
        user_t u;
        u = user_t'({k_t'(k_v), new_w});
        if (new_w) begin
            for (int n = 0; n < k_v*k_v; n++) send_word(w_mem[n], u);
            send_word(bias_v, u);
        end
        for (int n = 0; n < IMG_R*IMG_C; n++) send_word(x_mem[n], u);
        if (timeouts != 0) return;
        i_in_valid <= 1'b0;
        @(negedge clk);
        check_bit(o_in_ready, 1'b0, "input ready after image loaded");
        @(posedge clk);
    endtask

    task automatic collect_results(input int ready_pct);
        int   n;
        int   got;
        int   idle;
        logic held;
        acc_t held_data;
        if (timeouts != 0) return;
        n    = exp_q.size();
        got  = 0;
        idle = 0;
        held = 1'b0;
        held_data = '0;
        while (got < n) begin
            i_out_ready <= (($urandom % 100) < ready_pct);
            @(negedge clk);
            if (held) begin                           // stalled word must not move
                check_bit(o_out_valid, 1'b1, "valid dropped under back-pressure");
                check_acc(o_out_data, held_data, "data changed under back-pressure");
            end
            if (n - got > FIFO_DEPTH) check_bit(o_in_ready, 1'b0, "input ready mid frame");
            held      = o_out_valid && !i_out_ready;
            held_data = o_out_data;
            if (o_out_valid && i_out_ready) begin
                check_acc(o_out_data, exp_q.pop_front(), $sformatf("result %0d", got));
                got++;
                idle = 0;
            end else if (idle == WAIT_LIMIT) begin
                $display("timeout at %0t: result %0d of %0d never arrived", $time, got, n);
                timeouts++;
                return;
            end else begin
                idle++;
            end
            @(posedge clk);
        end
        i_out_ready <= 1'b0;
        @(negedge clk);
        check_bit(o_out_valid, 1'b0, "extra result after frame");
        idle = 0;
        while (!o_in_ready) begin                     // loader released by frame done
            if (idle == WAIT_LIMIT) begin
                $display("timeout at %0t: input side not released after frame", $time);
                timeouts++;
                return;
            end
            idle++;
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    //----------------------------------------
    // directed tests
    //----------------------------------------
    task automatic test_reset_levels();
        @(negedge clk);
        check_bit(o_out_valid, 1'b0, "output valid after reset");
        check_bit(o_in_ready, 1'b1, "input ready after reset");
        @(posedge clk);
    endtask

    task automatic test_k3_random();
        fill_weights_random(3);
        fill_image_random();
        model_conv();
        send_frame(1'b1);
        collect_results(100);
    endtask

    task automatic test_weight_reuse();
        fill_image_random();                          // weights and bias stay as before
        model_conv();
        send_frame(1'b0);
        collect_results(100);
    endtask

    task automatic test_extreme(input int k);
        k_v = k;
        for (int n = 0; n < k*k; n++) w_mem[n] = pick_extreme();
        bias_v = pick_extreme();
        for (int n = 0; n < IMG_R*IMG_C; n++) x_mem[n] = pick_extreme();
        if (k == MAX_K) begin                         // worst case first window
            for (int n = 0; n < k*k; n++) w_mem[n] = D_MIN;
            for (int n = 0; n < k*IMG_C; n++) x_mem[n] = D_MIN;
            bias_v = D_MAX;
        end
        model_conv();
        send_frame(1'b1);
        collect_results(100);
    endtask

    task automatic test_backpressure();
        fill_weights_random(4);
        fill_image_random();
        model_conv();
        send_frame(1'b1);
        collect_results(50);
    endtask

    initial begin
        seed_val    = $urandom(41);
        checks      = 0;
        errors      = 0;
        timeouts    = 0;
        k_v         = 1;
        bias_v      = '0;
        reset       = 1'b1;
        i_in_data   = '0;
        i_in_valid  = 1'b0;
        i_in_user   = '0;
        i_out_ready = 1'b0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        test_reset_levels();
        test_k3_random();
        test_weight_reuse();
        test_extreme(1);
        test_extreme(MAX_K);
        test_backpressure();
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== src/conv_top.sv ====
//----------------------------------------
// streaming 2-D convolution engine top
//----------------------------------------
module conv_top (
    input  logic            clk,
    input  logic            reset,
    input  conv_pkg::data_t i_in_data,
    input  logic            i_in_valid,
    input  conv_pkg::user_t i_in_user,
    output logic            o_in_ready,
    output conv_pkg::acc_t  o_out_data,
    output logic            o_out_valid,
    input  logic            i_out_ready
);
    import conv_pkg::*;

    logic    loaded, frame_done;
    k_t      k;
    data_t   bias, x_data, w_data;
    x_addr_t x_addr;
    w_addr_t w_addr;
    logic    win_start, tap_step, pos_step, last_tap, last_pos;
    logic    mac_init, mac_valid;
    acc_t    acc;
    logic    fifo_valid, fifo_ready;

    load_ctrl u_load (
        .clk(clk), .reset(reset),
        .i_data(i_in_data), .i_valid(i_in_valid), .i_user(i_in_user), .o_ready(o_in_ready),
        .i_frame_done(frame_done), .o_loaded(loaded), .o_k(k), .o_bias(bias),
        .i_x_addr(x_addr), .i_w_addr(w_addr), .o_x_data(x_data), .o_w_data(w_data)
    );

    window_counter u_win (
        .clk(clk), .reset(reset), .i_k(k),
        .i_win_start(win_start), .i_tap_step(tap_step), .i_pos_step(pos_step),
        .o_x_addr(x_addr), .o_w_addr(w_addr), .o_last_tap(last_tap), .o_last_pos(last_pos)
    );

    conv_ctrl u_ctrl (
        .clk(clk), .reset(reset), .i_loaded(loaded), .o_frame_done(frame_done),
        .o_win_start(win_start), .o_tap_step(tap_step), .o_pos_step(pos_step),
        .i_last_tap(last_tap), .i_last_pos(last_pos),
        .o_mac_init(mac_init), .o_mac_valid(mac_valid),
        .o_fifo_valid(fifo_valid), .i_fifo_ready(fifo_ready)
    );

    mac_acc u_mac (
        .clk(clk), .reset(reset), .i_x(x_data), .i_w(w_data), .i_bias(bias),
        .i_init(mac_init), .i_valid(mac_valid), .o_acc(acc)
    );

    out_fifo u_fifo (
        .clk(clk), .reset(reset),
        .i_data(acc), .i_valid(fifo_valid), .o_ready(fifo_ready),
        .o_data(o_out_data), .o_valid(o_out_valid), .i_ready(i_out_ready)
    );

endmodule

// ==== src/out_fifo.sv ====
//----------------------------------------
// result FIFO, circular with look-ahead read
//----------------------------------------
module out_fifo (
    input  logic           clk,
    input  logic           reset,
    input  conv_pkg::acc_t i_data,
    input  logic           i_valid,
    output logic           o_ready,
    output conv_pkg::acc_t o_data,
    output logic           o_valid,
    input  logic           i_ready
);
    import conv_pkg::*;

    acc_t      mem [FIFO_DEPTH];
    fifo_ptr_t wr_ptr, rd_ptr, rd_next;
    fifo_cnt_t count;
    logic      full, wr_en, rd_en;

    assign full    = (count == fifo_cnt_t'(FIFO_DEPTH));
    assign o_valid = (count != '0);
    assign o_ready = !full || rd_en;      // full but draining still accepts
    assign wr_en   = i_valid && o_ready;
    assign rd_en   = o_valid && i_ready;

    // where the read pointer lands after this cycle
    always_comb begin
        rd_next = rd_ptr;
        if (rd_en) begin
            rd_next = (rd_ptr == fifo_ptr_t'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + fifo_ptr_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) mem[wr_ptr] <= i_data;
        if (wr_en && wr_ptr == rd_next) o_data <= i_data;   // bypass to head
        else o_data <= mem[rd_next];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            rd_ptr <= rd_next;
            if (wr_en) begin
                wr_ptr <= (wr_ptr == fifo_ptr_t'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + fifo_ptr_t'(1);
            end
            if (wr_en && !rd_en) count <= count + fifo_cnt_t'(1);
            else if (!wr_en && rd_en) count <= count - fifo_cnt_t'(1);
        end
    end

    // a write never lands on the unread head entry
    a_no_overwrite: assert property (@(posedge clk) disable iff (reset)
        (wr_en && !rd_en && count != '0) |-> (wr_ptr != rd_ptr));

    // a read never passes the write pointer
    a_no_underrun: assert property (@(posedge clk) disable iff (reset)
        rd_en |-> (wr_ptr != rd_ptr || full));

endmodule

// ==== src/mac_acc.sv ====
//----------------------------------------
// two-stage multiply-accumulate, bias preload
//----------------------------------------
module mac_acc (
    input  logic            clk,
    input  logic            reset,
    input  conv_pkg::data_t i_x,
    input  conv_pkg::data_t i_w,
    input  conv_pkg::data_t i_bias,
    input  logic            i_init,
    input  logic            i_valid,
    output conv_pkg::acc_t  o_acc
);
    import conv_pkg::*;

    logic signed [2*IN_W-1:0] prod_q;   // registered product
    logic                     valid_d;

    always_ff @(posedge clk) begin
        prod_q <= i_x * i_w;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_d <= 1'b0;
            o_acc   <= '0;
        end else begin
            valid_d <= i_valid;
            if (i_init) o_acc <= acc_t'(i_bias);               // sign extended
            else if (valid_d) o_acc <= o_acc + acc_t'(prod_q);
        end
    end

endmodule

// ==== src/conv_ctrl.sv ====
//----------------------------------------
// convolution sequencer: one window at a time
// through the MAC and into the result FIFO
//----------------------------------------
module conv_ctrl (
    input  logic clk,
    input  logic reset,
    input  logic i_loaded,
    output logic o_frame_done,
    output logic o_win_start,
    output logic o_tap_step,
    output logic o_pos_step,
    input  logic i_last_tap,
    input  logic i_last_pos,
    output logic o_mac_init,
    output logic o_mac_valid,
    output logic o_fifo_valid,
    input  logic i_fifo_ready
);
    import conv_pkg::*;

    conv_state_t state, state_next;
    logic [1:0]  wait_cnt;   // MAC drain count

    always_comb begin
        state_next   = state;
        o_frame_done = 1'b0;
        o_win_start  = 1'b0;
        o_tap_step   = 1'b0;
        o_pos_step   = 1'b0;
        o_mac_init   = 1'b0;
        o_mac_valid  = 1'b0;
        o_fifo_valid = 1'b0;
        case (state)
            IDLE:    if (i_loaded) state_next = SET_MAC;
            SET_MAC: begin
                o_win_start = 1'b1;
                o_mac_init  = 1'b1;      // bias into accumulator
                state_next  = READ;
            end
            READ: begin
                o_tap_step = 1'b1;       // tap 0 address is out, move to tap 1
                state_next = COMPUTE;
            end
            COMPUTE: begin
                o_mac_valid = 1'b1;
                o_tap_step  = !i_last_tap;
                if (i_last_tap) state_next = WAIT;
            end
            WAIT:    if (wait_cnt == 2'(MAC_LAT - 1)) state_next = WRITE;
            WRITE: begin
                o_fifo_valid = 1'b1;
                if (i_fifo_ready) begin
                    o_pos_step = 1'b1;
                    state_next = i_last_pos ? DONE : SET_MAC;
                end
            end
            DONE: begin
                o_frame_done = 1'b1;     // releases the loader
                state_next   = IDLE;
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= IDLE;
            wait_cnt <= '0;
        end else begin
            state    <= state_next;
            wait_cnt <= (state == WAIT) ? wait_cnt + 2'd1 : 2'd0;
        end
    end

    // a window never steps past its last tap
    a_tap_step_bound: assert property (@(posedge clk) disable iff (reset)
        o_tap_step |-> !i_last_tap);

endmodule

// ==== src/window_counter.sv ====
//----------------------------------------
// output position and kernel tap counters,
// forms image and weight read addresses
//----------------------------------------
module window_counter (
    input  logic              clk,
    input  logic              reset,
    input  conv_pkg::k_t      i_k,
    input  logic              i_win_start,
    input  logic              i_tap_step,
    input  logic              i_pos_step,
    output conv_pkg::x_addr_t o_x_addr,
    output conv_pkg::w_addr_t o_w_addr,
    output logic              o_last_tap,
    output logic              o_last_pos
);
    import conv_pkg::*;

    row_t    r, last_r;
    col_t    c, last_c;
    tap_t    i, j;          // address tap, one ahead of the MAC
    w_addr_t tap_cnt;       // taps issued in this window

    assign last_r = row_t'(IMG_R - int'(i_k));
    assign last_c = col_t'(IMG_C - int'(i_k));

    assign o_x_addr   = x_addr_t'((r + i) * IMG_C + c + j);
    assign o_w_addr   = w_addr_t'(i) * w_addr_t'(i_k) + w_addr_t'(j);
    assign o_last_tap = (tap_cnt == w_addr_t'(i_k) * w_addr_t'(i_k));
    assign o_last_pos = (r == last_r) && (c == last_c);

    always_ff @(posedge clk) begin
        if (reset || i_win_start) begin
            i       <= '0;
            j       <= '0;
            tap_cnt <= '0;
        end else if (i_tap_step) begin
            tap_cnt <= tap_cnt + w_addr_t'(1);
            if (j == tap_t'(i_k - k_t'(1))) begin
                j <= '0;
                i <= (i == tap_t'(i_k - k_t'(1))) ? tap_t'(0) : i + tap_t'(1);
            end else begin
                j <= j + tap_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            r <= '0;
            c <= '0;
        end else if (i_pos_step) begin
            if (c == last_c) begin
                c <= '0;
                r <= (r == last_r) ? row_t'(0) : r + row_t'(1);   // back to 0 for next frame
            end else begin
                c <= c + col_t'(1);
            end
        end
    end

endmodule

// ==== src/load_ctrl.sv ====
//----------------------------------------
// input stream loader: weights, bias and image
// into RAM, then serves reads until frame done
//----------------------------------------
module load_ctrl (
    input  logic              clk,
    input  logic              reset,
    input  conv_pkg::data_t   i_data,
    input  logic              i_valid,
    input  conv_pkg::user_t   i_user,
    output logic              o_ready,
    input  logic              i_frame_done,
    output logic              o_loaded,
    output conv_pkg::k_t      o_k,
    output conv_pkg::data_t   o_bias,
    input  conv_pkg::x_addr_t i_x_addr,
    input  conv_pkg::w_addr_t i_w_addr,
    output conv_pkg::data_t   o_x_data,
    output conv_pkg::data_t   o_w_data
);
    import conv_pkg::*;

    typedef enum logic [2:0] {L_IDLE, L_LOAD_W, L_LOAD_B, L_LOAD_X, L_LOADED} load_state_t;

    load_state_t state, state_next;
    x_addr_t     wr_idx, wr_idx_next;   // shared write index
    k_t          k_reg, k_cur;
    w_addr_t     last_w;
    logic        hs, new_w;
    logic        w_wr_en, x_wr_en;
    w_addr_t     w_addr;
    x_addr_t     x_addr;

    assign hs       = i_valid && o_ready;
    assign new_w    = i_user[0];
    assign o_ready  = (state != L_LOADED);
    assign o_loaded = (state == L_LOADED);
    assign o_k      = k_reg;

    // k is taken from the user field on the first weight word
    assign k_cur  = (state == L_IDLE) ? i_user[3:1] : k_reg;
    assign last_w = w_addr_t'(k_cur) * w_addr_t'(k_cur) - w_addr_t'(1);

    assign w_wr_en = hs && ((state == L_IDLE && new_w) || state == L_LOAD_W);
    assign x_wr_en = hs && ((state == L_IDLE && !new_w) || state == L_LOAD_X);
    assign w_addr  = o_loaded ? i_w_addr : w_addr_t'(wr_idx);
    assign x_addr  = o_loaded ? i_x_addr : wr_idx;

    //----------------------------------------
    // next state
    //----------------------------------------
    always_comb begin
        state_next  = state;
        wr_idx_next = wr_idx;
        case (state)
            L_IDLE, L_LOAD_W: begin
                if (hs && state == L_IDLE && !new_w) begin
                    wr_idx_next = x_addr_t'(1);     // x[0] written now
                    state_next  = L_LOAD_X;
                end else if (hs && w_addr_t'(wr_idx) == last_w) begin
                    wr_idx_next = '0;
                    state_next  = L_LOAD_B;
                end else if (hs) begin
                    wr_idx_next = wr_idx + x_addr_t'(1);
                    state_next  = L_LOAD_W;
                end
            end
            L_LOAD_B: if (hs) state_next = L_LOAD_X;
            L_LOAD_X: begin
                if (hs) begin
                    wr_idx_next = wr_idx + x_addr_t'(1);   // wraps to 0 after 63
                    if (wr_idx == x_addr_t'(IMG_R * IMG_C - 1)) state_next = L_LOADED;
                end
            end
            L_LOADED: if (i_frame_done) state_next = L_IDLE;
            default:  state_next = L_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= L_IDLE;
            wr_idx <= '0;
            k_reg  <= '0;
        end else begin
            state  <= state_next;
            wr_idx <= wr_idx_next;
            if (hs && state == L_IDLE && new_w) k_reg <= i_user[3:1];
        end
    end

    always_ff @(posedge clk) begin
        if (hs && state == L_LOAD_B) o_bias <= i_data;   // held across reuse frames
    end

    sample_ram #(.DEPTH(MAX_K * MAX_K)) w_ram (
        .clk     (clk),
        .i_wr_en (w_wr_en),
        .i_addr  (w_addr),
        .i_data  (i_data),
        .o_data  (o_w_data)
    );

    sample_ram #(.DEPTH(IMG_R * IMG_C)) x_ram (
        .clk     (clk),
        .i_wr_en (x_wr_en),
        .i_addr  (x_addr),
        .i_data  (i_data),
        .o_data  (o_x_data)
    );

    // a new-weights frame must carry a usable kernel size
    a_k_range: assert property (@(posedge clk) disable iff (reset)
        (hs && state == L_IDLE && new_w) |=> (k_reg >= k_t'(1) && k_reg <= k_t'(MAX_K)));

endmodule

// ==== src/sample_ram.sv ====
//----------------------------------------
// single-port sample RAM with registered read
//----------------------------------------
module sample_ram #(
    parameter int DEPTH = 64
) (
    input  logic                       clk,
    input  logic                       i_wr_en,
    input  logic [$clog2(DEPTH)-1:0]   i_addr,
    input  conv_pkg::data_t            i_data,
    output conv_pkg::data_t            o_data
);
    import conv_pkg::*;

    data_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (i_wr_en) mem[i_addr] <= i_data;
        o_data <= mem[i_addr];   // read before write
    end

endmodule

// ==== src/conv_pkg.sv ====
//----------------------------------------
// conv package: geometry, widths, vector types
// and the convolution controller states
//----------------------------------------
package conv_pkg;

    localparam int IN_W       = 18;           // sample, weight and bias width
    localparam int ACC_W      = 41;           // 25 full-scale products plus bias
    localparam int IMG_R      = 8;
    localparam int IMG_C      = 8;
    localparam int MAX_K      = 5;
    localparam int FIFO_DEPTH = IMG_C - 1;    // 7 result slots
    localparam int MAC_LAT    = 2;            // drain cycles after last product

    typedef logic signed [IN_W-1:0]  data_t;
    typedef logic signed [ACC_W-1:0] acc_t;
    typedef logic [2:0]              k_t;
    typedef logic [3:0]              user_t;  // {k, new weights flag}
    typedef logic [5:0]              x_addr_t;
    typedef logic [4:0]              w_addr_t;
    typedef logic [2:0]              row_t;
    typedef logic [2:0]              col_t;
    typedef logic [2:0]              tap_t;
    typedef logic [2:0]              fifo_ptr_t;
    typedef logic [2:0]              fifo_cnt_t;

    typedef enum logic [2:0] {
        IDLE, SET_MAC, READ, COMPUTE, WAIT, WRITE, DONE
    } conv_state_t;

endpackage
